/* compile.f */
+incdir+.
riscv_bu_pkg.sv
riscv_bp.sv
riscv_bu.sv
riscv_bu_top.sv
riscv_bu_checker.sv
tb_riscv_bu.sv

/* riscv_bp.sv */
//////////////////////////////////////////////////////////////////////
// Global-history branch predictor with two-bit saturating counters
// Lookup is combinational from id_pc_i and the history register
// The update arrives one cycle after lookup; the write index is the
// stored PC bits XORed with the history returned by the branch unit
// Index capture freezes while ex_stall_i is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "riscv_bu_macros.svh"

module riscv_bp (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ex_stall_i,
  input  riscv_bu_pkg::xlen_t    id_pc_i,
  input  logic                   bu_bp_update_i,
  input  logic                   bu_bp_btaken_i,
  input  riscv_bu_pkg::bp_hist_t bu_bp_history_update_i,
  output riscv_bu_pkg::bp_pred_t bp_predict_o,
  output riscv_bu_pkg::bp_hist_t bp_history_o
);

  localparam int TBL_BITS  = `RV_BP_TABLE_BITS;
  localparam int HIST_BITS = `RV_BP_GLOBAL_BITS;
  localparam int TBL_SIZE  = 1 << TBL_BITS;

  riscv_bu_pkg::bp_pred_t [TBL_SIZE-1:0] cnt_q;
  logic [HIST_BITS:0]                    hist_q;
  riscv_bu_pkg::bp_idx_t                 pc_idx;
  riscv_bu_pkg::bp_idx_t                 rd_idx;
  riscv_bu_pkg::bp_idx_t                 lu_pc_q;
  riscv_bu_pkg::bp_idx_t                 wr_idx;
  riscv_bu_pkg::bp_pred_t                cur_cnt;
  riscv_bu_pkg::bp_pred_t                nxt_cnt;

  //////////////////////////////////////////////////////////////////////
  // Lookup

  // Newest bit belongs to the branch being resolved and is left out
  assign bp_history_o = hist_q[HIST_BITS:1];

  assign pc_idx       = id_pc_i[TBL_BITS+1:2];
  assign rd_idx       = pc_idx ^ {{(TBL_BITS-HIST_BITS){1'b0}}, bp_history_o};
  assign bp_predict_o = cnt_q[rd_idx];

  // PC part of the lookup index, for the update one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lu_pc_q <= '0;
    end else if (!ex_stall_i) begin
      lu_pc_q <= pc_idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Update

  // Same index as at lookup since the BU returns the history it saw
  assign wr_idx  = lu_pc_q ^ {{(TBL_BITS-HIST_BITS){1'b0}}, bu_bp_history_update_i};
  assign cur_cnt = cnt_q[wr_idx];

  // Saturating step toward the resolved direction
  always_comb begin
    nxt_cnt = cur_cnt;
    if (bu_bp_btaken_i) begin
      if (cur_cnt != 2'b11) nxt_cnt = cur_cnt + 2'b01;
    end else begin
      if (cur_cnt != 2'b00) nxt_cnt = cur_cnt - 2'b01;
    end
  end

  // All counters start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= {TBL_SIZE{2'b01}};
      hist_q <= '0;
    end else if (bu_bp_update_i) begin
      cnt_q[wr_idx] <= nxt_cnt;
      hist_q        <= {hist_q[HIST_BITS-1:0], bu_bp_btaken_i};
    end
  end

endmodule

/* riscv_bu.sv */
//////////////////////////////////////////////////////////////////////
// Branch unit, resolves JAL, JALR, conditional branches and FENCE.I
// All outputs are registered, one cycle after the ID inputs
// No return stack, so every JALR flushes
// bu_nxt_pc_o and bu_exc_o hold under ex_stall_i; the flush, cache and
// predictor outputs recompute every cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "riscv_bu_macros.svh"

module riscv_bu (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ex_stall_i,
  input  logic                   st_flush_i,
  input  logic                   later_exc_i,
  input  riscv_bu_pkg::xlen_t    id_pc_i,
  input  riscv_bu_pkg::id_insn_t id_insn_i,
  input  riscv_bu_pkg::exc_t     id_exc_i,
  input  riscv_bu_pkg::xlen_t    opa_i,
  input  riscv_bu_pkg::xlen_t    opb_i,
  input  riscv_bu_pkg::bp_pred_t id_bp_predict_i,
  input  riscv_bu_pkg::bp_hist_t id_bp_history_i,
  output riscv_bu_pkg::xlen_t    bu_nxt_pc_o,
  output logic                   bu_flush_o,
  output logic                   cm_ic_invalidate_o,
  output logic                   cm_dc_clean_o,
  output riscv_bu_pkg::exc_t     bu_exc_o,
  output logic                   bu_bp_btaken_o,
  output logic                   bu_bp_update_o,
  output riscv_bu_pkg::bp_hist_t bu_bp_history_update_o
);

  localparam int XLEN    = `RV_XLEN;
  localparam bit HAS_RVC = (`RV_HAS_RVC != 0);

  riscv_bu_pkg::opc_t    opc;
  riscv_bu_pkg::immsb_t  immsb;
  riscv_bu_pkg::immuj_t  immuj;
  riscv_bu_pkg::xlen_t   ext_immsb;
  riscv_bu_pkg::xlen_t   ext_immuj;
  riscv_bu_pkg::xlen_t   pc_step;
  riscv_bu_pkg::xlen_t   seq_pc;
  riscv_bu_pkg::xlen_t   jalr_sum;
  riscv_bu_pkg::xlen_t   nxt_pc;
  riscv_bu_pkg::exc_t    nxt_exc;
  logic                  is_16bit;
  logic                  btaken;
  logic                  bp_update;
  logic                  pipeflush;
  logic                  ic_invalidate;
  logic                  dc_clean;
  logic                  misaligned;

  //////////////////////////////////////////////////////////////////////
  // Decode

  always_comb begin
    opc = riscv_bu_pkg::OP_OTHER;
    if (!id_insn_i.bubble) begin
      case (id_insn_i.instr[6:0])
        riscv_bu_pkg::OPC_JAL:  opc = riscv_bu_pkg::OP_JAL;
        riscv_bu_pkg::OPC_JALR: opc = riscv_bu_pkg::OP_JALR;
        riscv_bu_pkg::OPC_BRANCH: begin
          case (id_insn_i.instr[14:12])
            3'b000:  opc = riscv_bu_pkg::OP_BEQ;
            3'b001:  opc = riscv_bu_pkg::OP_BNE;
            3'b100:  opc = riscv_bu_pkg::OP_BLT;
            3'b101:  opc = riscv_bu_pkg::OP_BGE;
            3'b110:  opc = riscv_bu_pkg::OP_BLTU;
            3'b111:  opc = riscv_bu_pkg::OP_BGEU;
            default: opc = riscv_bu_pkg::OP_OTHER;
          endcase
        end
        // FENCE.I is MISC-MEM with funct3 001
        riscv_bu_pkg::OPC_MISCMEM: begin
          if (id_insn_i.instr[14:12] == 3'b001) opc = riscv_bu_pkg::OP_FENCE_I;
        end
        default: opc = riscv_bu_pkg::OP_OTHER;
      endcase
    end
  end

  // Immediates
  assign immsb = {id_insn_i.instr[31], id_insn_i.instr[7], id_insn_i.instr[30:25],
                  id_insn_i.instr[11:8], 1'b0};
  assign immuj = {id_insn_i.instr[31], id_insn_i.instr[19:12], id_insn_i.instr[20],
                  id_insn_i.instr[30:21], 1'b0};
  assign ext_immsb = {{(XLEN-$bits(immsb)){immsb[$bits(immsb)-1]}}, immsb};
  assign ext_immuj = {{(XLEN-$bits(immuj)){immuj[$bits(immuj)-1]}}, immuj};

  // Sequential PC, compressed words step by 2
  assign is_16bit = HAS_RVC & (id_insn_i.instr[1:0] != 2'b11);
  assign pc_step  = is_16bit ? riscv_bu_pkg::xlen_t'(2) : riscv_bu_pkg::xlen_t'(4);
  assign seq_pc   = id_pc_i + pc_step;
  assign jalr_sum = opa_i + opb_i;

  //////////////////////////////////////////////////////////////////////
  // Resolve

  always_comb begin
    btaken        = 1'b0;
    bp_update     = 1'b0;
    ic_invalidate = 1'b0;
    dc_clean      = 1'b0;
    case (opc)
      riscv_bu_pkg::OP_JAL:    btaken = 1'b1;
      riscv_bu_pkg::OP_JALR:   btaken = 1'b1;
      riscv_bu_pkg::OP_BEQ:    btaken = (opa_i == opb_i);
      riscv_bu_pkg::OP_BNE:    btaken = (opa_i != opb_i);
      riscv_bu_pkg::OP_BLT:    btaken = ($signed(opa_i) <  $signed(opb_i));
      riscv_bu_pkg::OP_BGE:    btaken = ($signed(opa_i) >= $signed(opb_i));
      riscv_bu_pkg::OP_BLTU:   btaken = (opa_i <  opb_i);
      riscv_bu_pkg::OP_BGEU:   btaken = (opa_i >= opb_i);
      riscv_bu_pkg::OP_FENCE_I: begin
        ic_invalidate = 1'b1;
        dc_clean      = 1'b1;
      end
      default: btaken = 1'b0;
    endcase

    // Flush and next PC per class
    case (opc)
      riscv_bu_pkg::OP_JAL: begin
        // Predicted-taken JAL was already redirected in IF
        pipeflush = ~id_bp_predict_i[1];
        nxt_pc    = id_pc_i + ext_immuj;
      end
      riscv_bu_pkg::OP_JALR: begin
        pipeflush = 1'b1;
        nxt_pc    = {jalr_sum[XLEN-1:1], 1'b0};
      end
      riscv_bu_pkg::OP_FENCE_I: begin
        pipeflush = 1'b1;
        nxt_pc    = id_pc_i + riscv_bu_pkg::xlen_t'(4);
      end
      riscv_bu_pkg::OP_OTHER: begin
        pipeflush = 1'b0;
        nxt_pc    = seq_pc;
      end
      default: begin
        // Conditional branches
        bp_update = 1'b1;
        pipeflush = btaken ^ id_bp_predict_i[1];
        nxt_pc    = btaken ? id_pc_i + ext_immsb : seq_pc;
      end
    endcase
  end

  // Only a taken target can be misaligned
  assign misaligned = btaken & (HAS_RVC ? nxt_pc[0] : |nxt_pc[1:0]);

  always_comb begin
    nxt_exc                        = id_exc_i;
    nxt_exc.misaligned_instruction = id_exc_i.misaligned_instruction | misaligned;
    nxt_exc.any                    = id_exc_i.any | misaligned;
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_flush_o             <= 1'b1;
      cm_ic_invalidate_o     <= 1'b0;
      cm_dc_clean_o          <= 1'b0;
      bu_bp_btaken_o         <= 1'b0;
      bu_bp_update_o         <= 1'b0;
      bu_bp_history_update_o <= '0;
    end else begin
      bu_flush_o             <= pipeflush;
      cm_ic_invalidate_o     <= ic_invalidate;
      cm_dc_clean_o          <= dc_clean;
      bu_bp_btaken_o         <= btaken;
      bu_bp_update_o         <= bp_update;
      bu_bp_history_update_o <= id_bp_history_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_nxt_pc_o <= `RV_PC_INIT;
    end else if (!ex_stall_i) begin
      bu_nxt_pc_o <= nxt_pc;
    end
  end

  // Instruction behind a flush or a later exception is dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_exc_o <= '0;
    end else if (!ex_stall_i) begin
      if (bu_flush_o || st_flush_i || later_exc_i) begin
        bu_exc_o <= '0;
      end else begin
        bu_exc_o <= nxt_exc;
      end
    end
  end

endmodule

/* riscv_bu_checker.sv */
//////////////////////////////////////////////////////////////////////
// Output monitor for the branch resolution slice
// Samples 2 ns before each rising edge, so the clock must be 20 ns
// Registered checks refer to the instruction of the previous cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module riscv_bu_checker (
  input  logic                   clk_i,
  input  logic                   pred_en_i,
  input  logic                   reg_en_i,
  input  riscv_bu_pkg::id_insn_t cur_insn_i,
  input  riscv_bu_pkg::id_insn_t prev_insn_i,
  input  riscv_bu_pkg::bp_pred_t exp_pred_i,
  input  riscv_bu_pkg::xlen_t    exp_pc_i,
  input  logic [3:0]             exp_flags_i,
  input  riscv_bu_pkg::exc_t     exp_exc_i,
  input  riscv_bu_pkg::bp_pred_t bp_predict_i,
  input  riscv_bu_pkg::xlen_t    bu_nxt_pc_i,
  input  logic [3:0]             dut_flags_i,
  input  riscv_bu_pkg::exc_t     bu_exc_i,
  output int                     err_cnt_o,
  output int                     chk_cnt_o
);

  int errors = 0;
  int checks = 0;

  assign err_cnt_o = errors;
  assign chk_cnt_o = checks;

  // Opcode name for messages, from the RV32 base encoding
  function automatic riscv_bu_pkg::opc_t decode_opc(input riscv_bu_pkg::id_insn_t insn);
    riscv_bu_pkg::opc_t op;
    op = riscv_bu_pkg::OP_OTHER;
    if (!insn.bubble) begin
      case (insn.instr[6:0])
        7'h6f: op = riscv_bu_pkg::OP_JAL;
        7'h67: op = riscv_bu_pkg::OP_JALR;
        7'h0f: op = (insn.instr[14:12] == 3'd1) ? riscv_bu_pkg::OP_FENCE_I : op;
        7'h63: begin
          case (insn.instr[14:12])
            3'd0: op = riscv_bu_pkg::OP_BEQ;
            3'd1: op = riscv_bu_pkg::OP_BNE;
            3'd4: op = riscv_bu_pkg::OP_BLT;
            3'd5: op = riscv_bu_pkg::OP_BGE;
            3'd6: op = riscv_bu_pkg::OP_BLTU;
            3'd7: op = riscv_bu_pkg::OP_BGEU;
            default: op = riscv_bu_pkg::OP_OTHER;
          endcase
        end
        default: op = riscv_bu_pkg::OP_OTHER;
      endcase
    end
    return op;
  endfunction

  task automatic compare_value(input string what, input riscv_bu_pkg::id_insn_t insn,
                               input logic [31:0] got, input logic [31:0] exp);
    riscv_bu_pkg::opc_t op;
    op     = decode_opc(insn);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERROR @%0t: %s %s got %h expected %h", $time, op.name(), what, got, exp);
    end
  endtask

  // Flags are {flush, ic_invalidate, dc_clean, btaken}
  always @(posedge clk_i) begin
    #18;
    if (pred_en_i) begin
      compare_value("bp_predict", cur_insn_i, 32'(bp_predict_i), 32'(exp_pred_i));
    end
    if (reg_en_i) begin
      compare_value("nxt_pc", prev_insn_i, bu_nxt_pc_i, exp_pc_i);
      compare_value("flush", prev_insn_i, 32'(dut_flags_i[3]), 32'(exp_flags_i[3]));
      compare_value("ic_invalidate", prev_insn_i, 32'(dut_flags_i[2]), 32'(exp_flags_i[2]));
      compare_value("dc_clean", prev_insn_i, 32'(dut_flags_i[1]), 32'(exp_flags_i[1]));
      compare_value("btaken", prev_insn_i, 32'(dut_flags_i[0]), 32'(exp_flags_i[0]));
      compare_value("exc", prev_insn_i, 32'(bu_exc_i), 32'(exp_exc_i));
    end
  end

endmodule

/* riscv_bu_macros.svh */
//////////////////////////////////////////////////////////////////////
// Subsystem-wide build parameters for the branch unit slice
// Every file that sizes a bus or a table includes this header, so
// the package, the RTL and the testbench always agree
// RV_BP_TABLE_BITS must be at least RV_BP_GLOBAL_BITS
// RV_HAS_RVC set to 0 makes bit 1 of a taken target misaligned
//////////////////////////////////////////////////////////////////////

`ifndef RISCV_BU_MACROS_SVH
`define RISCV_BU_MACROS_SVH

// Data and address width
`define RV_XLEN           32
// Next PC after reset
`define RV_PC_INIT        'h200
// Global history length and log2 of the counter table size
`define RV_BP_GLOBAL_BITS 2
`define RV_BP_TABLE_BITS  6
// Compressed instruction support
`define RV_HAS_RVC        1

`endif

/* riscv_bu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Types shared by the branch unit, the predictor and the testbench
// Widths follow the macros header
// Only the opcodes that the branch unit resolves are named here
//////////////////////////////////////////////////////////////////////

`include "riscv_bu_macros.svh"

package riscv_bu_pkg;

  // Data path and instruction words
  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [31:0]         instr_t;
  typedef logic [6:0]          opcode_t;

  // Instruction as handed over by ID
  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } id_insn_t;

  // Predictor values
  typedef logic [`RV_BP_GLOBAL_BITS-1:0] bp_hist_t;
  typedef logic [`RV_BP_TABLE_BITS-1:0]  bp_idx_t;
  typedef logic [1:0]                    bp_pred_t;

  // Exception record, 4 bits
  typedef struct packed {
    logic any;
    logic misaligned_instruction;
    logic illegal_instruction;
    logic breakpoint;
  } exc_t;

  // Raw immediates, bit 0 always zero
  typedef logic [12:0] immsb_t;
  typedef logic [20:0] immuj_t;

  // Major opcodes seen by the branch unit
  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_JALR    = 7'b1100111;
  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_MISCMEM = 7'b0001111;

  // Resolved operation
  typedef enum logic [3:0] {
    OP_OTHER,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_FENCE_I
  } opc_t;

endpackage

/* riscv_bu_stim.txt */
# stall pc instr bubble opa opb id_exc later_exc st_flush | exp: bp_predict (this cycle)
# then nxt_pc flush ic_inv dc_clean btaken exc (registered, next cycle)
0 00000200 00000013 0 00000000 00000000 0 0 0 1 00000204 0 0 0 0 0
0 00000204 00000001 0 00000000 00000000 0 0 0 1 00000206 0 0 0 0 0
0 00000206 00000013 0 00000000 00000000 0 0 0 1 0000020a 0 0 0 0 0
0 0000020a 00000001 0 00000000 00000000 0 0 0 1 0000020c 0 0 0 0 0
0 00000300 00000863 0 00000005 00000005 0 0 0 1 00000310 1 0 0 1 0
0 00000310 00000013 0 00000000 00000000 0 0 0 1 00000314 0 0 0 0 0
0 00000320 00001863 0 00000005 00000005 0 0 0 1 00000324 0 0 0 0 0
0 00000324 00000013 0 00000000 00000000 0 0 0 1 00000328 0 0 0 0 0
0 00000330 00004863 0 ffffffff 00000001 0 0 0 1 00000340 1 0 0 1 0
0 00000340 00000013 0 00000000 00000000 0 0 0 1 00000344 0 0 0 0 0
0 00000350 00006863 0 ffffffff 00000001 0 0 0 1 00000354 0 0 0 0 0
0 00000354 00000013 0 00000000 00000000 0 0 0 1 00000358 0 0 0 0 0
0 00000360 00005863 0 ffffffff 00000001 0 0 0 1 00000364 0 0 0 0 0
0 00000364 00000013 0 00000000 00000000 0 0 0 1 00000368 0 0 0 0 0
0 00000370 00007863 0 ffffffff 00000001 0 0 0 1 00000380 1 0 0 1 0
0 00000380 00000013 0 00000000 00000000 0 0 0 1 00000384 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 1 000003d0 1 0 0 1 0
0 000003d0 00000013 0 00000000 00000000 0 0 0 1 000003d4 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 1 000003d0 1 0 0 1 0
0 000003d0 00000013 0 00000000 00000000 0 0 0 1 000003d4 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 1 000003d0 1 0 0 1 0
0 000003d0 00000013 0 00000000 00000000 0 0 0 1 000003d4 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 2 000003d0 0 0 0 1 0
0 000003d0 00000013 0 00000000 00000000 0 0 0 1 000003d4 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 3 000003d0 0 0 0 1 0
0 000003d0 00000013 0 00000000 00000000 0 0 0 1 000003d4 0 0 0 0 0
0 000003c0 00000863 0 00000000 00000000 0 0 0 3 000003d0 0 0 0 1 0
0 000003d0 0200006f 0 00000000 00000000 0 0 0 1 000003f0 1 0 0 1 0
0 000003c0 0200006f 0 00000000 00000000 0 0 0 3 000003e0 0 0 0 1 0
0 000003e0 00000067 0 00001001 00000004 0 0 0 1 00001004 1 0 0 1 0
0 00001004 00000013 0 00000000 00000000 0 0 0 1 00001008 0 0 0 0 0
0 00001009 0200006f 0 00000000 00000000 0 0 0 1 00001029 1 0 0 1 c
0 00001100 0000100f 0 00000000 00000000 0 0 0 1 00001104 1 1 1 0 0
0 00001104 00000013 0 00000000 00000000 0 0 0 1 00001108 0 0 0 0 0
0 00001108 00000013 0 00000000 00000000 a 0 0 1 0000110c 0 0 0 0 a
0 0000110c 00000013 0 00000000 00000000 a 1 0 2 00001110 0 0 0 0 0
0 00001110 00000013 0 00000000 00000000 a 0 1 1 00001114 0 0 0 0 0
0 00001114 00000013 0 00000000 00000000 a 0 0 1 00001118 0 0 0 0 a
1 00001118 00000013 0 00000000 00000000 0 0 0 1 00001118 0 0 0 0 a
1 00001118 00000013 0 00000000 00000000 0 0 0 1 00001118 0 0 0 0 a
0 00001118 00000013 0 00000000 00000000 0 0 0 1 0000111c 0 0 0 0 0
0 0000111c 00000001 0 00000000 00000000 0 0 0 1 0000111e 0 0 0 0 0

/* riscv_bu_top.sv */
//////////////////////////////////////////////////////////////////////
// Branch resolution slice, predictor and branch unit in a loop
// bp_predict_o is combinational; all other outputs lag ID by one cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module riscv_bu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  riscv_bu_pkg::xlen_t    id_pc_i,
  input  riscv_bu_pkg::id_insn_t id_insn_i,
  input  riscv_bu_pkg::exc_t     id_exc_i,
  input  riscv_bu_pkg::xlen_t    opa_i,
  input  riscv_bu_pkg::xlen_t    opb_i,
  input  logic                   ex_stall_i,
  input  logic                   st_flush_i,
  input  logic                   later_exc_i,
  output riscv_bu_pkg::xlen_t    bu_nxt_pc_o,
  output logic                   bu_flush_o,
  output logic                   cm_ic_invalidate_o,
  output logic                   cm_dc_clean_o,
  output logic                   bu_btaken_o,
  output riscv_bu_pkg::exc_t     bu_exc_o,
  output riscv_bu_pkg::bp_pred_t bp_predict_o
);

  // Predictor to branch unit
  riscv_bu_pkg::bp_hist_t bp_history;
  // Branch unit back to predictor
  logic                   bu_bp_update;
  riscv_bu_pkg::bp_hist_t bu_bp_history_update;

  riscv_bp u_bp (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .ex_stall_i             (ex_stall_i),
    .id_pc_i                (id_pc_i),
    .bu_bp_update_i         (bu_bp_update),
    .bu_bp_btaken_i         (bu_btaken_o),
    .bu_bp_history_update_i (bu_bp_history_update),
    .bp_predict_o           (bp_predict_o),
    .bp_history_o           (bp_history)
  );

  riscv_bu u_bu (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .ex_stall_i             (ex_stall_i),
    .st_flush_i             (st_flush_i),
    .later_exc_i            (later_exc_i),
    .id_pc_i                (id_pc_i),
    .id_insn_i              (id_insn_i),
    .id_exc_i               (id_exc_i),
    .opa_i                  (opa_i),
    .opb_i                  (opb_i),
    .id_bp_predict_i        (bp_predict_o),
    .id_bp_history_i        (bp_history),
    .bu_nxt_pc_o            (bu_nxt_pc_o),
    .bu_flush_o             (bu_flush_o),
    .cm_ic_invalidate_o     (cm_ic_invalidate_o),
    .cm_dc_clean_o          (cm_dc_clean_o),
    .bu_exc_o               (bu_exc_o),
    .bu_bp_btaken_o         (bu_btaken_o),
    .bu_bp_update_o         (bu_bp_update),
    .bu_bp_history_update_o (bu_bp_history_update)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_riscv_bu > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_riscv_bu > sim.log 2>&1 || { echo "Simulation did not run cleanly"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* tb_riscv_bu.sv */
//////////////////////////////////////////////////////////////////////
// Testbench that plays the ID stage for the branch resolution slice
// Rows of riscv_bu_stim.txt are applied one per cycle, 2 ns after
// the rising edge; ID inputs stay constant through a stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "riscv_bu_macros.svh"

module tb_riscv_bu;

  localparam int MAX_ROWS = 128;

  typedef struct packed {
    logic                   stall;
    riscv_bu_pkg::xlen_t    pc;
    riscv_bu_pkg::id_insn_t insn;
    riscv_bu_pkg::xlen_t    opa;
    riscv_bu_pkg::xlen_t    opb;
    riscv_bu_pkg::exc_t     exc;
    logic                   later;
    logic                   stflush;
    riscv_bu_pkg::bp_pred_t pred;
    riscv_bu_pkg::xlen_t    nxt_pc;
    logic [3:0]             flags;
    riscv_bu_pkg::exc_t     exp_exc;
  } stim_row_t;

  logic                   clk_i, rst_ni, ex_stall_i, st_flush_i, later_exc_i;
  riscv_bu_pkg::xlen_t    id_pc_i, opa_i, opb_i, bu_nxt_pc_o;
  riscv_bu_pkg::id_insn_t id_insn_i, prev_insn;
  riscv_bu_pkg::exc_t     id_exc_i, bu_exc_o;
  riscv_bu_pkg::bp_pred_t bp_predict_o;
  logic                   bu_flush_o, cm_ic_invalidate_o, cm_dc_clean_o, bu_btaken_o;
  logic                   pred_en, reg_en;
  logic                   rows_loaded;
  stim_row_t              rows [MAX_ROWS];
  stim_row_t              exp_row;
  int                     n_rows = 0;
  int                     err_cnt, chk_cnt, fd, n;
  logic [31:0]            f [16];
  string                  line;

  riscv_bu_top uut (
    .clk_i, .rst_ni, .id_pc_i, .id_insn_i, .id_exc_i, .opa_i, .opb_i,
    .ex_stall_i, .st_flush_i, .later_exc_i, .bu_nxt_pc_o, .bu_flush_o,
    .cm_ic_invalidate_o, .cm_dc_clean_o, .bu_btaken_o, .bu_exc_o, .bp_predict_o
  );

  riscv_bu_checker u_chk (
    .clk_i, .pred_en_i(pred_en), .reg_en_i(reg_en), .cur_insn_i(id_insn_i),
    .prev_insn_i(prev_insn), .exp_pred_i(exp_row.pred), .exp_pc_i(exp_row.nxt_pc),
    .exp_flags_i(exp_row.flags), .exp_exc_i(exp_row.exp_exc), .bp_predict_i(bp_predict_o),
    .bu_nxt_pc_i(bu_nxt_pc_o),
    .dut_flags_i({bu_flush_o, cm_ic_invalidate_o, cm_dc_clean_o, bu_btaken_o}),
    .bu_exc_i(bu_exc_o), .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Watchdog sized from the stimulus length
  initial begin
    wait (rows_loaded === 1'b1);
    #((n_rows + 20) * 20);
    $display("Run timed out before all stimulus rows were checked");
    $display("Test failed");
    $finish;
  end

  task automatic load_rows();
    fd = $fopen("riscv_bu_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file riscv_bu_stim.txt");
    end else begin
      while (!$feof(fd) && n_rows < MAX_ROWS) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
          if (n == 16) begin
            rows[n_rows] = {f[0][0], f[1], f[2], f[3][0], f[4], f[5], f[6][3:0], f[7][0],
                            f[8][0], f[9][1:0], f[10], f[11][0], f[12][0], f[13][0],
                            f[14][0], f[15][3:0]};
            n_rows = n_rows + 1;
          end
        end
      end
      $fclose(fd);
      if (n_rows == 0) begin
        $display("The stimulus file holds no usable rows");
      end
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    ex_stall_i  = 1'b0;
    st_flush_i  = 1'b0;
    later_exc_i = 1'b0;
    id_pc_i     = '0;
    opa_i       = '0;
    opb_i       = '0;
    id_exc_i    = '0;
    id_insn_i   = '{instr: 32'h0000_0013, bubble: 1'b1};
    prev_insn   = id_insn_i;
    pred_en     = 1'b0;
    reg_en      = 1'b0;
    exp_row     = '0;
    rows_loaded = 1'b0;
    load_rows();
    rows_loaded = 1'b1;
    if (n_rows == 0) begin
      $display("Test failed");
      $finish;
    end else begin
      repeat (5) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      for (int k = 0; k <= n_rows; k++) begin
        if (k > 0) begin
          @(posedge clk_i);
          #2;
        end
        prev_insn = id_insn_i;
        // Row k-1 results are due now; on the first row the reset values are
        if (k == 0) begin
          exp_row        = '0;
          exp_row.nxt_pc = `RV_PC_INIT;
          exp_row.flags  = 4'b1000;
        end else begin
          exp_row = rows[k-1];
        end
        if (k < n_rows) begin
          ex_stall_i   = rows[k].stall;
          id_pc_i      = rows[k].pc;
          id_insn_i    = rows[k].insn;
          opa_i        = rows[k].opa;
          opb_i        = rows[k].opb;
          id_exc_i     = rows[k].exc;
          later_exc_i  = rows[k].later;
          st_flush_i   = rows[k].stflush;
          exp_row.pred = rows[k].pred;
        end
        pred_en = (k < n_rows);
        reg_en  = 1'b1;
      end
      @(posedge clk_i);
      #2;
      pred_en = 1'b0;
      reg_en  = 1'b0;
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule
